// ==== design/chan_reg_ring.sv ====
`timescale 1ns/10ps
`default_nettype none

module chan_reg_ring import fm_reg_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire slot_info_t cur_slot,
	input  wire logic       commit,
	input  wire wr_req_t    commit_req,
	output ch_params_t      ch_params
);

	ch_params_t ring_p [NUM_CH];
	ch_latch_t  ring_l [NUM_CH];
	ch_params_t base_p;
	ch_params_t merged_p;
	ch_latch_t  base_l;
	ch_latch_t  merged_l;
	logic [7:0] d;
	logic       init;

	assign d = commit_req.data;

	// first turn after reset replaces the ring contents
	assign base_p = init ? CH_PARAMS_RST : ring_p[NUM_CH-1];
	assign base_l = init ? ch_latch_t'('0) : ring_l[NUM_CH-1];

	always_comb begin
		merged_p = base_p;
		merged_l = base_l;
		if (commit) begin
			case (commit_req.cls)
				RC_FB_ALG: begin
					merged_p.fb  = d[5:3];
					merged_p.alg = d[2:0];
				end
				RC_PAN_AMS_PMS: begin
					merged_p.rl  = d[7:6];
					merged_p.ams = d[5:4];
					merged_p.pms = d[2:0];
				end
				// held back until the low byte arrives
				RC_BLOCK_FNHI: begin
					merged_l.block = d[5:3];
					merged_l.fnhi  = d[2:0];
				end
				RC_FNUM_LO: begin
					merged_p.block = base_l.block;
					merged_p.fnum  = {base_l.fnhi, d};
				end
				default: begin
				end
			endcase
		end
	end

	assign ch_params = merged_p;

	always_ff @(posedge clk) begin
		ring_p[0] <= merged_p;
		ring_l[0] <= merged_l;
		for (int i = 1; i < NUM_CH; i++) begin
			ring_p[i] <= ring_p[i-1];
			ring_l[i] <= ring_l[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			init <= 1'b1;
		end else if (init && cur_slot.ch == ch_t'(NUM_CH - 1)) begin
			init <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/fm_reg_pkg.sv ====
`default_nettype none

package fm_reg_pkg;

	localparam int NUM_CH    = 6;
	localparam int NUM_OP    = 4;
	localparam int NUM_SLOTS = 24;

	typedef logic [4:0]  slot_t;
	typedef logic [2:0]  ch_t;
	typedef logic [1:0]  op_t;
	typedef logic [10:0] fnum_t;
	typedef logic [2:0]  block_t;
	typedef logic [4:0]  rate5_t;
	typedef logic [3:0]  rate4_t;
	typedef logic [6:0]  tl_t;

	typedef enum logic [3:0] {
		RC_KEYON       = 4'd0,
		RC_FB_ALG      = 4'd1,
		RC_BLOCK_FNHI  = 4'd2,
		RC_FNUM_LO     = 4'd3,
		RC_PAN_AMS_PMS = 4'd4,
		RC_DT_MUL      = 4'd5,
		RC_TL          = 4'd6,
		RC_KS_AR       = 4'd7,
		RC_AM_D1R      = 4'd8,
		RC_D2R         = 4'd9,
		RC_D1L_RR      = 4'd10,
		RC_SSG         = 4'd11
	} reg_class_e;

	typedef struct packed {
		reg_class_e cls;
		ch_t        ch;
		op_t        op;
		logic [7:0] data;
	} wr_req_t;

	typedef struct packed {
		ch_t  ch;
		op_t  op;
		logic zero;
	} slot_info_t;

	typedef struct packed {
		logic [1:0] rl;
		logic [2:0] fb;
		logic [2:0] alg;
		logic [1:0] ams;
		logic [2:0] pms;
		block_t     block;
		fnum_t      fnum;
	} ch_params_t;

	typedef struct packed {
		tl_t        tl;
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [1:0] ks;
		rate5_t     ar;
		logic       amen;
		rate5_t     d1r;
		rate5_t     d2r;
		rate4_t     d1l;
		rate4_t     rr;
		logic       ssg_en;
		logic [2:0] ssg_eg;
	} op_params_t;

	typedef struct packed {
		block_t     block;
		logic [2:0] fnhi;
	} ch_latch_t;

	// both pan outputs on after reset
	localparam ch_params_t CH_PARAMS_RST = '{
		rl: 2'b11, fb: 3'd0, alg: 3'd0, ams: 2'd0, pms: 3'd0, block: '0, fnum: '0
	};

	// channel is the inner count
	function automatic slot_t slot_of(slot_info_t s);
		return slot_t'(s.op) * slot_t'(NUM_CH) + slot_t'(s.ch);
	endfunction

endpackage

`default_nettype wire

// ==== design/fm_reg_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_reg_top import fm_reg_pkg::*; (
	input  wire logic    clk,
	input  wire logic    rst,
	input  wire logic    req,
	input  wire wr_req_t req_data,
	output logic         ack,
	output slot_info_t   out_slot,
	output ch_params_t   ch_params,
	output op_params_t   op_params,
	output logic         keyon
);

	slot_info_t cur_slot;
	logic       commit;
	wr_req_t    commit_req;
	ch_params_t ch_s2;
	op_params_t op_s2;
	logic       kon_s2;

	slot_sequencer u_seq (
		.clk      (clk),
		.rst      (rst),
		.cur_slot (cur_slot)
	);

	host_write_port u_port (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.req_data   (req_data),
		.ack        (ack),
		.cur_slot   (cur_slot),
		.commit     (commit),
		.commit_req (commit_req)
	);

	chan_reg_ring u_chan (
		.clk        (clk),
		.rst        (rst),
		.cur_slot   (cur_slot),
		.commit     (commit),
		.commit_req (commit_req),
		.ch_params  (ch_s2)
	);

	op_reg_ring u_op (
		.clk        (clk),
		.rst        (rst),
		.cur_slot   (cur_slot),
		.commit     (commit),
		.commit_req (commit_req),
		.op_params  (op_s2)
	);

	keyon_ctrl u_kon (
		.clk        (clk),
		.rst        (rst),
		.cur_slot   (cur_slot),
		.commit     (commit),
		.commit_req (commit_req),
		.keyon      (kon_s2)
	);

	// one output stage keeps slot and data aligned
	always_ff @(posedge clk) begin
		if (rst) begin
			out_slot <= '{ch: '0, op: '0, zero: 1'b1};
			keyon    <= 1'b0;
		end else begin
			out_slot <= cur_slot;
			keyon    <= kon_s2;
		end
	end

	always_ff @(posedge clk) begin
		ch_params <= ch_s2;
		op_params <= op_s2;
	end

endmodule

`default_nettype wire

// ==== design/host_write_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module host_write_port import fm_reg_pkg::*; (
	input  wire logic    clk,
	input  wire logic    rst,
	input  wire logic    req,
	input  wire wr_req_t req_data,
	output logic         ack,
	input  wire slot_info_t cur_slot,
	output logic         commit,
	output wr_req_t      commit_req
);

	typedef enum logic [1:0] {
		IDLE,
		WAIT_SLOT,
		ACK_HIGH,
		WAIT_REQ_LOW
	} state_e;

	state_e  state;
	wr_req_t held;
	logic    ch_wide;
	logic    slot_hit;
	logic    take;

	// channel-wide classes ignore the operator
	always_comb begin
		case (held.cls)
			RC_KEYON, RC_FB_ALG, RC_BLOCK_FNHI, RC_FNUM_LO, RC_PAN_AMS_PMS: ch_wide = 1'b1;
			default: ch_wide = 1'b0;
		endcase
	end

	assign slot_hit   = (cur_slot.ch == held.ch) && (ch_wide || cur_slot.op == held.op);
	assign take       = (state == IDLE) && req && !ack;
	assign commit     = (state == WAIT_SLOT) && slot_hit;
	assign commit_req = held;

	always_ff @(posedge clk) begin
		if (take) begin
			held <= req_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			ack   <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (take) begin
						state <= WAIT_SLOT;
					end
				end
				WAIT_SLOT: begin
					// ack follows the commit cycle
					if (slot_hit) begin
						state <= ACK_HIGH;
						ack   <= 1'b1;
					end
				end
				ACK_HIGH, WAIT_REQ_LOW: begin
					if (!req) begin
						state <= IDLE;
						ack   <= 1'b0;
					end else begin
						state <= WAIT_REQ_LOW;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/keyon_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module keyon_ctrl import fm_reg_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire slot_info_t cur_slot,
	input  wire logic       commit,
	input  wire wr_req_t    commit_req,
	output logic            keyon
);

	// one bit per slot indexed like the operator memory
	logic [NUM_SLOTS-1:0] kon;
	logic                 kon_wr;
	slot_t                cur_idx;

	assign kon_wr  = commit && (commit_req.cls == RC_KEYON);
	assign cur_idx = slot_of(cur_slot);

	always_ff @(posedge clk) begin
		if (rst) begin
			kon <= '0;
		end else if (kon_wr) begin
			// data bit 4 is operator 0
			for (int o = 0; o < NUM_OP; o++) begin
				kon[o * NUM_CH + int'(commit_req.ch)] <= commit_req.data[4 + o];
			end
		end
	end

	// a write in this slot shows right away
	assign keyon = kon_wr ? commit_req.data[4 + int'(cur_slot.op)] : kon[cur_idx];

endmodule

`default_nettype wire

// ==== design/op_reg_ring.sv ====
`timescale 1ns/10ps
`default_nettype none

module op_reg_ring import fm_reg_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire slot_info_t cur_slot,
	input  wire logic       commit,
	input  wire wr_req_t    commit_req,
	output op_params_t      op_params
);

	op_params_t mem [NUM_SLOTS];
	op_params_t rd_q;
	op_params_t base;
	op_params_t merged;
	slot_t      cur_idx;
	slot_t      next_idx;
	logic [7:0] d;
	logic       init;

	assign d        = commit_req.data;
	assign cur_idx  = slot_of(cur_slot);
	assign next_idx = (cur_idx == slot_t'(NUM_SLOTS - 1)) ? slot_t'(0) : cur_idx + 1'b1;

	// rd_q was fetched one slot early
	assign base = init ? op_params_t'('0) : rd_q;

	always_comb begin
		merged = base;
		if (commit) begin
			case (commit_req.cls)
				RC_DT_MUL: begin
					merged.dt1 = d[6:4];
					merged.mul = d[3:0];
				end
				RC_TL: merged.tl = d[6:0];
				RC_KS_AR: begin
					merged.ks = d[7:6];
					merged.ar = d[4:0];
				end
				RC_AM_D1R: begin
					merged.amen = d[7];
					merged.d1r  = d[4:0];
				end
				RC_D2R: merged.d2r = d[4:0];
				RC_D1L_RR: begin
					merged.d1l = d[7:4];
					merged.rr  = d[3:0];
				end
				RC_SSG: begin
					merged.ssg_en = d[3];
					merged.ssg_eg = d[2:0];
				end
				default: begin
				end
			endcase
		end
	end

	assign op_params = merged;

	always_ff @(posedge clk) begin
		mem[cur_idx] <= merged;
		rd_q         <= mem[next_idx];
	end

	// clear pass over all 24 slots
	always_ff @(posedge clk) begin
		if (rst) begin
			init <= 1'b1;
		end else if (init && cur_idx == slot_t'(NUM_SLOTS - 1)) begin
			init <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/slot_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module slot_sequencer import fm_reg_pkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	output slot_info_t cur_slot
);

	logic last_ch;
	logic last_op;

	assign last_ch = cur_slot.ch == ch_t'(NUM_CH - 1);
	assign last_op = cur_slot.op == op_t'(NUM_OP - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			cur_slot.ch   <= '0;
			cur_slot.op   <= '0;
			cur_slot.zero <= 1'b1;
		end else begin
			if (last_ch) begin
				cur_slot.ch <= '0;
				// operator steps once per channel sweep
				if (last_op) begin
					cur_slot.op <= '0;
				end else begin
					cur_slot.op <= cur_slot.op + 1'b1;
				end
			end else begin
				cur_slot.ch <= cur_slot.ch + 1'b1;
			end
			// marker follows the slot it describes
			cur_slot.zero <= last_ch && last_op;
		end
	end

endmodule

`default_nettype wire

// ==== dv/fm_reg_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_reg_asserts import fm_reg_pkg::*; (
	input wire logic       clk,
	input wire logic       rst,
	input wire logic       req,
	input wire logic       ack,
	input wire logic       commit,
	input wire slot_info_t cur_slot
);

	int fails = 0;

	// ack only answers a held request
	ack_rise_with_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req))
		else begin
			fails++;
			$error("ack rose while req was low");
		end

	ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
		$fell(ack) |-> !$past(req))
		else begin
			fails++;
			$error("ack fell before req was seen low");
		end

	// channel is the inner count
	slot_steps: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) |-> (($past(cur_slot.ch) == ch_t'(NUM_CH - 1)) ?
			(cur_slot.ch == 3'd0 && cur_slot.op == $past(cur_slot.op) + 2'd1) :
			(cur_slot.ch == $past(cur_slot.ch) + 3'd1 && cur_slot.op == $past(cur_slot.op))))
		else begin
			fails++;
			$error("slot did not advance by one");
		end

	zero_marks_slot0: assert property (@(posedge clk) disable iff (rst)
		cur_slot.zero == (cur_slot.ch == 3'd0 && cur_slot.op == 2'd0))
		else begin
			fails++;
			$error("zero marker out of step with the slot");
		end

	no_commit_in_ack: assert property (@(posedge clk) disable iff (rst) !(commit && ack))
		else begin
			fails++;
			$error("commit fired while ack was high");
		end

endmodule

bind host_write_port fm_reg_asserts u_asserts (
	.clk      (clk),
	.rst      (rst),
	.req      (req),
	.ack      (ack),
	.commit   (commit),
	.cur_slot (cur_slot)
);

`default_nettype wire

// ==== dv/fm_reg_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_reg_checker import fm_reg_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire wr_req_t    req_data,
	input  wire logic       ack,
	input  wire slot_info_t out_slot,
	input  wire ch_params_t ch_params,
	input  wire op_params_t op_params,
	input  wire logic       keyon,
	output int              errors
);

	// register model indexed like the output slots
	ch_params_t           chp [NUM_CH];
	ch_latch_t            lat [NUM_CH];
	op_params_t           opp [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] kon_m;
	logic                 in_rst = 1'b1;
	logic                 ack_q;
	int                   cnt;

	task automatic apply_write(input wr_req_t w);
		ch_t   c;
		slot_t s;
		int    o;
		c = w.ch;
		s = slot_t'(int'(w.op) * NUM_CH + int'(w.ch));
		case (w.cls)
			RC_KEYON: begin
				for (o = 0; o < NUM_OP; o++) begin
					kon_m[slot_t'(o * NUM_CH + int'(c))] = w.data[3'(4 + o)];
				end
			end
			RC_FB_ALG: begin
				chp[c].fb  = w.data[5:3];
				chp[c].alg = w.data[2:0];
			end
			RC_PAN_AMS_PMS: begin
				chp[c].rl  = w.data[7:6];
				chp[c].ams = w.data[5:4];
				chp[c].pms = w.data[2:0];
			end
			RC_BLOCK_FNHI: begin
				lat[c].block = w.data[5:3];
				lat[c].fnhi  = w.data[2:0];
			end
			// latched high part lands with the low byte
			RC_FNUM_LO: begin
				chp[c].block = lat[c].block;
				chp[c].fnum  = {lat[c].fnhi, w.data};
			end
			RC_DT_MUL: begin
				opp[s].dt1 = w.data[6:4];
				opp[s].mul = w.data[3:0];
			end
			RC_TL: opp[s].tl = w.data[6:0];
			RC_KS_AR: begin
				opp[s].ks = w.data[7:6];
				opp[s].ar = w.data[4:0];
			end
			RC_AM_D1R: begin
				opp[s].amen = w.data[7];
				opp[s].d1r  = w.data[4:0];
			end
			RC_D2R: opp[s].d2r = w.data[4:0];
			RC_D1L_RR: begin
				opp[s].d1l = w.data[7:4];
				opp[s].rr  = w.data[3:0];
			end
			RC_SSG: begin
				opp[s].ssg_en = w.data[3];
				opp[s].ssg_eg = w.data[2:0];
			end
			default: begin
			end
		endcase
	endtask

	always @(posedge clk) begin
		in_rst <= rst;
	end

	// outputs settle after the rising edge, so compare on the falling one
	always @(negedge clk) begin
		slot_info_t exp_s;
		ch_t        cc;
		slot_t      cs;
		if (in_rst) begin
			for (int i = 0; i < NUM_CH; i++) begin
				chp[i]    = '0;
				chp[i].rl = 2'b11;
				lat[i]    = '0;
			end
			for (int i = 0; i < NUM_SLOTS; i++) begin
				opp[i] = '0;
			end
			kon_m  = '0;
			cnt    = 0;
			ack_q  = 1'b0;
			errors = 0;
		end else begin
			// the committed slot is on the output when ack first shows
			if (ack && !ack_q) begin
				apply_write(req_data);
			end
			ack_q      = ack;
			cc         = ch_t'(cnt % NUM_CH);
			cs         = slot_t'(cnt);
			exp_s.ch   = cc;
			exp_s.op   = op_t'(cnt / NUM_CH);
			exp_s.zero = (cnt == 0);
			if (out_slot !== exp_s) begin
				$display("FAILED out_slot exp=%h got=%h", exp_s, out_slot);
				errors++;
			end
			if (ch_params !== chp[cc]) begin
				$display("FAILED ch_params slot %0d exp=%h got=%h", cnt, chp[cc], ch_params);
				errors++;
			end
			if (op_params !== opp[cs]) begin
				$display("FAILED op_params slot %0d exp=%h got=%h", cnt, opp[cs], op_params);
				errors++;
			end
			if (keyon !== kon_m[cs]) begin
				$display("FAILED keyon slot %0d exp=%h got=%h", cnt, kon_m[cs], keyon);
				errors++;
			end
			cnt = (cnt + 1) % NUM_SLOTS;
		end
	end

endmodule

`default_nettype wire

// ==== dv/fm_reg_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fm_reg_tb import fm_reg_pkg::*; ();

	localparam int PERIOD      = 100;
	localparam int NUM_ENTRIES = 18;
	localparam int NUM_RAND    = 16;
	// a write plus its readback turn stays under 60 cycles
	localparam int WATCH_CYCLES = (NUM_ENTRIES + NUM_RAND) * 60 + 200;

	typedef struct packed {
		reg_class_e cls;
		ch_t        ch;
		op_t        op;
		logic [7:0] data;
		logic       vis;
	} entry_t;

	logic       clk = 1'b0;
	logic       rst;
	logic       req;
	wr_req_t    req_data;
	logic       ack;
	slot_info_t out_slot;
	ch_params_t ch_params;
	op_params_t op_params;
	logic       keyon;
	int         chk_errors;
	int         rb_errors = 0;
	integer     seed;

	// vis low means nothing shows until the low frequency byte
	entry_t table_e [NUM_ENTRIES] = '{
		'{RC_TL,          3'd0, 2'd0, 8'h2a, 1'b1},
		'{RC_TL,          3'd5, 2'd3, 8'h7f, 1'b1},
		'{RC_KS_AR,       3'd2, 2'd1, 8'hc5, 1'b1},
		'{RC_DT_MUL,      3'd3, 2'd2, 8'h35, 1'b1},
		'{RC_AM_D1R,      3'd1, 2'd3, 8'h9b, 1'b1},
		'{RC_D2R,         3'd4, 2'd0, 8'h13, 1'b1},
		'{RC_D1L_RR,      3'd2, 2'd2, 8'ha6, 1'b1},
		'{RC_SSG,         3'd5, 2'd1, 8'h0d, 1'b1},
		'{RC_BLOCK_FNHI,  3'd1, 2'd0, 8'h2d, 1'b0},
		'{RC_FNUM_LO,     3'd1, 2'd2, 8'h9c, 1'b1},
		'{RC_BLOCK_FNHI,  3'd4, 2'd0, 8'h3f, 1'b0},
		'{RC_FNUM_LO,     3'd4, 2'd0, 8'h01, 1'b1},
		'{RC_FB_ALG,      3'd3, 2'd0, 8'h2e, 1'b1},
		'{RC_PAN_AMS_PMS, 3'd0, 2'd0, 8'h96, 1'b1},
		'{RC_KEYON,       3'd2, 2'd0, 8'hf0, 1'b1},
		'{RC_KEYON,       3'd5, 2'd0, 8'ha0, 1'b1},
		'{RC_KEYON,       3'd2, 2'd0, 8'h00, 1'b1},
		'{RC_TL,          3'd0, 2'd0, 8'h11, 1'b1}
	};

	always #(PERIOD / 2) clk = ~clk;

	fm_reg_top DUT (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.req_data  (req_data),
		.ack       (ack),
		.out_slot  (out_slot),
		.ch_params (ch_params),
		.op_params (op_params),
		.keyon     (keyon)
	);

	fm_reg_checker chk (
		.clk       (clk),
		.rst       (rst),
		.req_data  (req_data),
		.ack       (ack),
		.out_slot  (out_slot),
		.ch_params (ch_params),
		.op_params (op_params),
		.keyon     (keyon),
		.errors    (chk_errors)
	);

	// data bits each class owns
	function automatic logic [7:0] class_mask(input reg_class_e cls, input op_t op);
		case (cls)
			RC_KEYON:       return 8'h10 << op;
			RC_FB_ALG:      return 8'h3f;
			RC_FNUM_LO:     return 8'hff;
			RC_PAN_AMS_PMS: return 8'hf7;
			RC_DT_MUL:      return 8'h7f;
			RC_TL:          return 8'h7f;
			RC_KS_AR:       return 8'hdf;
			RC_AM_D1R:      return 8'h9f;
			RC_D2R:         return 8'h1f;
			RC_D1L_RR:      return 8'hff;
			RC_SSG:         return 8'h0f;
			default:        return 8'h00;
		endcase
	endfunction

	// output fields packed back into the host data layout
	function automatic logic [7:0] shown_bits(input reg_class_e cls, input op_t op);
		case (cls)
			RC_KEYON:       return {7'd0, keyon} << (4 + int'(op));
			RC_FB_ALG:      return {2'b00, ch_params.fb, ch_params.alg};
			RC_FNUM_LO:     return ch_params.fnum[7:0];
			RC_PAN_AMS_PMS: return {ch_params.rl, ch_params.ams, 1'b0, ch_params.pms};
			RC_DT_MUL:      return {1'b0, op_params.dt1, op_params.mul};
			RC_TL:          return {1'b0, op_params.tl};
			RC_KS_AR:       return {op_params.ks, 1'b0, op_params.ar};
			RC_AM_D1R:      return {op_params.amen, 2'b00, op_params.d1r};
			RC_D2R:         return {3'b000, op_params.d2r};
			RC_D1L_RR:      return {op_params.d1l, op_params.rr};
			RC_SSG:         return {4'h0, op_params.ssg_en, op_params.ssg_eg};
			default:        return 8'h00;
		endcase
	endfunction

	// full four-phase cycle started on a falling edge
	task automatic write_reg(input entry_t e);
		req_data.cls  = e.cls;
		req_data.ch   = e.ch;
		req_data.op   = e.op;
		req_data.data = e.data;
		req = 1'b1;
		@(negedge clk);
		while (!ack) begin
			@(negedge clk);
		end
		req = 1'b0;
		@(negedge clk);
		while (ack) begin
			@(negedge clk);
		end
	endtask

	task automatic read_back(input entry_t e);
		logic [7:0] mask;
		logic [7:0] got;
		string      sig;
		@(negedge clk);
		while (out_slot.ch != e.ch || out_slot.op != e.op) begin
			@(negedge clk);
		end
		mask = class_mask(e.cls, e.op);
		got  = shown_bits(e.cls, e.op) & mask;
		if (e.cls == RC_KEYON) begin
			sig = "keyon";
		end else if (e.cls <= RC_PAN_AMS_PMS) begin
			sig = "ch_params";
		end else begin
			sig = "op_params";
		end
		if (got !== (e.data & mask)) begin
			$display("FAILED %s class %0d ch %0d op %0d exp=%h got=%h",
				sig, e.cls, e.ch, e.op, e.data & mask, got);
			rb_errors++;
		end
	endtask

	initial begin
		entry_t e;
		int     total;
		seed     = 92;
		rst      = 1'b1;
		req      = 1'b0;
		req_data = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		// two idle turns of reset values
		repeat (2 * NUM_SLOTS) @(negedge clk);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			write_reg(table_e[i]);
			if (table_e[i].vis) begin
				read_back(table_e[i]);
			end
		end
		// random total levels over random slots
		for (int i = 0; i < NUM_RAND; i++) begin
			e.cls  = RC_TL;
			e.ch   = ch_t'($unsigned($random(seed)) % NUM_CH);
			e.op   = op_t'($unsigned($random(seed)) % NUM_OP);
			e.data = 8'($random(seed));
			e.vis  = 1'b1;
			write_reg(e);
			read_back(e);
		end
		repeat (2 * NUM_SLOTS) @(negedge clk);
		total = chk_errors + rb_errors + DUT.u_port.u_asserts.fails;
		$display("errors: checker %0d, readback %0d, assertions %0d",
			chk_errors, rb_errors, DUT.u_port.u_asserts.fails);
		if (total == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge clk);
		$display("timeout: the host writes did not finish within %0d cycles", WATCH_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the register bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fm_reg_tb -f sources.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vfm_reg_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1

// ==== sources.f ====
design/fm_reg_pkg.sv
design/slot_sequencer.sv
design/host_write_port.sv
design/chan_reg_ring.sv
design/op_reg_ring.sv
design/keyon_ctrl.sv
design/fm_reg_top.sv
dv/fm_reg_asserts.sv
dv/fm_reg_checker.sv
dv/fm_reg_tb.sv
